// File: rv_pkg.sv
package rv_pkg;

    ////////////////////
    // widths and basic types
    ////////////////////

    parameter int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    // ADDI x0,x0,0
    parameter word_t nop_instr = 32'h0000_0013;

    ////////////////////
    // encodings
    ////////////////////

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcode_t;

    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        SLT = 3'd5
    } alu_op_t;

    // same values as funct3
    typedef enum logic [2:0] {
        BEQ = 3'b000,
        BNE = 3'b001,
        BLT = 3'b100
    } br_cond_t;

    ////////////////////
    // stage bundles
    ////////////////////

    typedef struct packed {
        logic      valid;
        alu_op_t   alu_op;
        logic      use_imm;
        logic      is_load;
        logic      is_store;
        logic      writes_rd;
        logic      is_link;
        word_t     rs1;
        word_t     rs2;
        word_t     imm;
        word_t     link;
        reg_addr_t rd;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        logic      is_load;
        logic      is_store;
        logic      writes_rd;
        word_t     result;
        word_t     store_data;
        reg_addr_t rd;
    } ex_mem_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     value;
    } wb_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  write;
    } dmem_req_t;

endpackage

// File: fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage #(
    parameter rv_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          stall,
    input  logic          redirect,
    input  rv_pkg::word_t target,
    input  rv_pkg::word_t imem_rdata,
    output rv_pkg::word_t imem_addr,
    output rv_pkg::word_t instr,
    output rv_pkg::word_t instr_pc,
    output logic          instr_valid
);
    import rv_pkg::*;

    word_t pc;
    word_t pc_next;

    // branch target wins over the sequential path
    always_comb begin
        if (redirect) begin
            pc_next = target;
        end else begin
            pc_next = pc + 32'd4;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else if (!stall) begin
            pc <= pc_next;
        end
    end

    assign imem_addr = pc;

    // fetch to decode register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr       <= nop_instr;
            instr_pc    <= RESET_PC;
            instr_valid <= 1'b0;
        end else if (!stall) begin
            instr       <= imem_rdata;
            instr_pc    <= pc;
            instr_valid <= 1'b1;
        end
    end

endmodule

// File: reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::reg_addr_t rs1_addr,
    input  rv_pkg::reg_addr_t rs2_addr,
    input  rv_pkg::wb_t       wb,
    output rv_pkg::word_t     rs1_data,
    output rv_pkg::word_t     rs2_data
);
    import rv_pkg::*;

    // x0 has no storage
    word_t regs [1:31];

    // falling edge write, so decode sees it in the same cycle
    always_ff @(negedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && (wb.rd != 5'd0)) begin
            regs[wb.rd] <= wb.value;
        end
    end

    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

// File: decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              stall,
    input  rv_pkg::word_t     instr,
    input  rv_pkg::word_t     instr_pc,
    input  logic              instr_valid,
    input  rv_pkg::word_t     rs1_data,
    input  rv_pkg::word_t     rs2_data,
    output rv_pkg::reg_addr_t rs1_addr,
    output rv_pkg::reg_addr_t rs2_addr,
    output logic              redirect,
    output rv_pkg::word_t     target,
    output rv_pkg::id_ex_t    id_ex
);
    import rv_pkg::*;

    opcode_t    opcode;
    logic [2:0] funct3;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_j;
    logic       is_branch;
    logic       is_jal;
    logic       taken;
    id_ex_t     id_ex_d;

    assign opcode   = opcode_t'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];

    ////////////////////
    // immediates
    ////////////////////

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    ////////////////////
    // control decode
    ////////////////////

    always_comb begin
        id_ex_d        = '0;
        id_ex_d.alu_op = ADD;
        id_ex_d.rs1    = rs1_data;
        id_ex_d.rs2    = rs2_data;
        id_ex_d.imm    = imm_i;
        id_ex_d.link   = instr_pc + 32'd4;
        id_ex_d.rd     = instr[11:7];
        is_branch      = 1'b0;
        is_jal         = 1'b0;
        case (opcode)
            OP: begin
                id_ex_d.valid     = 1'b1;
                id_ex_d.writes_rd = 1'b1;
                case ({instr[30], funct3})
                    4'b0000: id_ex_d.alu_op = ADD;
                    4'b1000: id_ex_d.alu_op = SUB;
                    4'b0111: id_ex_d.alu_op = AND;
                    4'b0110: id_ex_d.alu_op = OR;
                    4'b0100: id_ex_d.alu_op = XOR;
                    4'b0010: id_ex_d.alu_op = SLT;
                    default: id_ex_d.valid  = 1'b0;
                endcase
            end
            OP_IMM: begin
                // addi only
                id_ex_d.valid     = (funct3 == 3'b000);
                id_ex_d.use_imm   = 1'b1;
                id_ex_d.writes_rd = 1'b1;
            end
            LOAD: begin
                id_ex_d.valid     = (funct3 == 3'b010);
                id_ex_d.is_load   = 1'b1;
                id_ex_d.writes_rd = 1'b1;
            end
            STORE: begin
                id_ex_d.valid    = (funct3 == 3'b010);
                id_ex_d.is_store = 1'b1;
                id_ex_d.imm      = imm_s;
            end
            BRANCH: begin
                is_branch     = (funct3 == BEQ) || (funct3 == BNE) || (funct3 == BLT);
                id_ex_d.valid = is_branch;
                id_ex_d.imm   = imm_b;
            end
            JAL: begin
                is_jal            = 1'b1;
                id_ex_d.valid     = 1'b1;
                id_ex_d.is_link   = 1'b1;
                id_ex_d.writes_rd = 1'b1;
                id_ex_d.imm       = imm_j;
            end
            default: ;
        endcase
        // unknown opcodes and empty slots go down as bubbles
        id_ex_d.valid = id_ex_d.valid & instr_valid;
    end

    ////////////////////
    // branch unit
    ////////////////////

    always_comb begin
        case (br_cond_t'(funct3))
            BEQ:     taken = (rs1_data == rs2_data);
            BNE:     taken = (rs1_data != rs2_data);
            BLT:     taken = ($signed(rs1_data) < $signed(rs2_data));
            default: taken = 1'b0;
        endcase
    end

    assign redirect = instr_valid && (is_jal || (is_branch && taken));
    assign target   = instr_pc + (is_jal ? imm_j : imm_b);

    // decode to execute register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex <= '0;
        end else if (!stall) begin
            id_ex <= id_ex_d;
        end
    end

endmodule

// File: execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            stall,
    input  rv_pkg::id_ex_t  id_ex,
    output rv_pkg::ex_mem_t ex_mem
);
    import rv_pkg::*;

    word_t   alu_b;
    word_t   alu_res;
    word_t   mem_addr;
    word_t   result;
    ex_mem_t ex_mem_d;

    ////////////////////
    // alu
    ////////////////////

    assign alu_b = id_ex.use_imm ? id_ex.imm : id_ex.rs2;

    always_comb begin
        case (id_ex.alu_op)
            ADD:     alu_res = id_ex.rs1 + alu_b;
            SUB:     alu_res = id_ex.rs1 - alu_b;
            AND:     alu_res = id_ex.rs1 & alu_b;
            OR:      alu_res = id_ex.rs1 | alu_b;
            XOR:     alu_res = id_ex.rs1 ^ alu_b;
            SLT:     alu_res = {31'd0, $signed(id_ex.rs1) < $signed(alu_b)};
            default: alu_res = '0;
        endcase
    end

    // load/store address
    assign mem_addr = id_ex.rs1 + id_ex.imm;

    always_comb begin
        if (id_ex.is_link) begin
            result = id_ex.link;
        end else if (id_ex.is_load || id_ex.is_store) begin
            result = mem_addr;
        end else begin
            result = alu_res;
        end
    end

    always_comb begin
        ex_mem_d.valid      = id_ex.valid;
        ex_mem_d.is_load    = id_ex.is_load;
        ex_mem_d.is_store   = id_ex.is_store;
        ex_mem_d.writes_rd  = id_ex.writes_rd;
        ex_mem_d.result     = result;
        ex_mem_d.store_data = id_ex.rs2;
        ex_mem_d.rd         = id_ex.rd;
    end

    // execute to memory register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem <= '0;
        end else if (!stall) begin
            ex_mem <= ex_mem_d;
        end
    end

endmodule

// File: memory_stage.sv
`timescale 1ns/1ps

module memory_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::ex_mem_t   ex_mem,
    input  logic              dmem_ready,
    input  rv_pkg::word_t     dmem_rdata,
    output logic              dmem_valid,
    output rv_pkg::dmem_req_t dmem_req,
    output logic              stall,
    output rv_pkg::wb_t       wb
);
    import rv_pkg::*;

    wb_t wb_d;

    // request held stable by the stall on ex_mem
    assign dmem_valid     = ex_mem.valid && (ex_mem.is_load || ex_mem.is_store);
    assign dmem_req.addr  = ex_mem.result;
    assign dmem_req.wdata = ex_mem.store_data;
    assign dmem_req.write = ex_mem.is_store;

    // only back-pressure source in the core
    assign stall = dmem_valid && !dmem_ready;

    always_comb begin
        wb_d.valid = ex_mem.valid && ex_mem.writes_rd && !stall;
        wb_d.rd    = ex_mem.rd;
        if (ex_mem.is_load) begin
            wb_d.value = dmem_rdata;
        end else begin
            wb_d.value = ex_mem.result;
        end
    end

    // memory to writeback register, bubble while waiting
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb <= '0;
        end else begin
            wb <= wb_d;
        end
    end

endmodule

// File: rv_core.sv
`timescale 1ns/1ps

module rv_core #(
    parameter rv_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::word_t     imem_rdata,
    input  logic              dmem_ready,
    input  rv_pkg::word_t     dmem_rdata,
    output rv_pkg::word_t     imem_addr,
    output logic              dmem_valid,
    output rv_pkg::dmem_req_t dmem_req,
    output rv_pkg::wb_t       wb
);
    import rv_pkg::*;

    logic      stall;
    logic      redirect;
    word_t     target;
    word_t     instr;
    word_t     instr_pc;
    logic      instr_valid;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;

    ////////////////////
    // fetch and decode
    ////////////////////

    fetch_stage #(
        .RESET_PC    (RESET_PC)
    ) u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall       (stall),
        .redirect    (redirect),
        .target      (target),
        .imem_rdata  (imem_rdata),
        .imem_addr   (imem_addr),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .instr_valid (instr_valid)
    );

    decode_stage u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall       (stall),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .instr_valid (instr_valid),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .redirect    (redirect),
        .target      (target),
        .id_ex       (id_ex)
    );

    // written back on the falling edge
    reg_file u_reg_file (
        .clk         (clk),
        .rst_n       (rst_n),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .wb          (wb),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data)
    );

    ////////////////////
    // execute and memory
    ////////////////////

    execute_stage u_execute (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall       (stall),
        .id_ex       (id_ex),
        .ex_mem      (ex_mem)
    );

    memory_stage u_memory (
        .clk         (clk),
        .rst_n       (rst_n),
        .ex_mem      (ex_mem),
        .dmem_ready  (dmem_ready),
        .dmem_rdata  (dmem_rdata),
        .dmem_valid  (dmem_valid),
        .dmem_req    (dmem_req),
        .stall       (stall),
        .wb          (wb)
    );

endmodule

// File: tb_tests.svh
`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

    task automatic test_reset();
        wb_t exp;
        test_name = "reset";
        prog_len = 0;
        put(i_type(3'b000, 7'b0010011, 5'd1, 5'd0, 1));
        reset_dut();
        @(negedge clk);
        check_word("reset release pc", reset_pc, imem_addr);
        // the first instruction needs four edges to reach writeback
        repeat (4) begin
            check_bit("reset release dmem_valid", 1'b0, dmem_valid);
            check_bit("reset release wb.valid", 1'b0, wb.valid);
            @(negedge clk);
        end
        exp = '{valid: 1'b1, rd: 5'd1, value: 32'd1};
        check_wb("reset first retire", exp, wb);
    endtask

    task automatic test_alu(logic rnd);
        prog_len = 0;
        put(i_type(3'b000, 7'b0010011, 5'd1, 5'd0, 5));
        put(i_type(3'b000, 7'b0010011, 5'd2, 5'd0, -3));
        // write to x0 is dropped
        put(i_type(3'b000, 7'b0010011, 5'd0, 5'd0, 7));
        put(i_type(3'b000, 7'b0010011, 5'd3, 5'd0, 9));
        put(r_type(7'h00, 3'b000, 5'd4, 5'd1, 5'd2));
        put(r_type(7'h20, 3'b000, 5'd5, 5'd1, 5'd2));
        put(r_type(7'h00, 3'b111, 5'd6, 5'd1, 5'd3));
        put(r_type(7'h00, 3'b110, 5'd7, 5'd1, 5'd3));
        put(r_type(7'h00, 3'b100, 5'd8, 5'd2, 5'd3));
        put(r_type(7'h00, 3'b010, 5'd9, 5'd2, 5'd1));
        put(r_type(7'h00, 3'b010, 5'd10, 5'd1, 5'd2));
        put(r_type(7'h00, 3'b000, 5'd11, 5'd0, 5'd0));
        run_program(rnd ? "alu_rand" : "alu", rnd);
    endtask

    task automatic test_mem(logic rnd);
        prog_len = 0;
        put(i_type(3'b000, 7'b0010011, 5'd1, 5'd0, 64));
        put(i_type(3'b000, 7'b0010011, 5'd2, 5'd0, 32'h123));
        put(i_type(3'b000, 7'b0010011, 5'd0, 5'd0, 0));
        put(i_type(3'b000, 7'b0010011, 5'd0, 5'd0, 0));
        put(s_type(5'd1, 5'd2, 8));
        put(i_type(3'b010, 7'b0000011, 5'd3, 5'd1, 8));
        // untouched word shows the fill pattern
        put(i_type(3'b010, 7'b0000011, 5'd4, 5'd1, 12));
        put(i_type(3'b000, 7'b0010011, 5'd0, 5'd0, 0));
        put(i_type(3'b000, 7'b0010011, 5'd0, 5'd0, 0));
        put(s_type(5'd1, 5'd1, -4));
        put(r_type(7'h00, 3'b000, 5'd5, 5'd3, 5'd4));
        run_program(rnd ? "mem_rand" : "mem", rnd);
    endtask

    task automatic test_branch(logic rnd);
        prog_len = 0;
        put(i_type(3'b000, 7'b0010011, 5'd1, 5'd0, 1));
        put(i_type(3'b000, 7'b0010011, 5'd2, 5'd0, 2));
        put(i_type(3'b000, 7'b0010011, 5'd0, 5'd0, 0));
        put(i_type(3'b000, 7'b0010011, 5'd0, 5'd0, 0));
        put(b_type(3'b000, 5'd1, 5'd2, 12));
        put(i_type(3'b000, 7'b0010011, 5'd3, 5'd0, 3));
        put(i_type(3'b000, 7'b0010011, 5'd4, 5'd0, 4));
        put(b_type(3'b001, 5'd1, 5'd2, 12));
        put(i_type(3'b000, 7'b0010011, 5'd5, 5'd0, 5));
        put(i_type(3'b000, 7'b0010011, 5'd6, 5'd0, 6));
        put(b_type(3'b100, 5'd2, 5'd1, 8));
        put(i_type(3'b000, 7'b0010011, 5'd7, 5'd0, 7));
        put(b_type(3'b100, 5'd1, 5'd2, 12));
        put(i_type(3'b000, 7'b0010011, 5'd8, 5'd0, 8));
        put(i_type(3'b000, 7'b0010011, 5'd9, 5'd0, 9));
        put(j_type(5'd10, 12));
        put(i_type(3'b000, 7'b0010011, 5'd11, 5'd0, 11));
        put(i_type(3'b000, 7'b0010011, 5'd12, 5'd0, 12));
        put(b_type(3'b000, 5'd1, 5'd1, 8));
        put(i_type(3'b000, 7'b0010011, 5'd13, 5'd0, 13));
        put(i_type(3'b000, 7'b0010011, 5'd14, 5'd0, 14));
        run_program(rnd ? "branch_rand" : "branch", rnd);
    endtask

`endif

// File: tb_core.sv
`timescale 1ns/1ps

module tb_core;
    import rv_pkg::*;

    localparam word_t reset_pc = 32'h0000_0100;
    // two passes over programs of 12, 11 and 21 instructions
    localparam int total_instrs = 88;
    localparam int watchdog_cycles = total_instrs * 20 + 600;

    logic      clk;
    logic      rst_n;
    word_t     imem_addr;
    word_t     imem_rdata;
    logic      dmem_ready;
    word_t     dmem_rdata;
    logic      dmem_valid;
    dmem_req_t dmem_req;
    wb_t       wb;

    word_t     prog [0:63];
    int        prog_len;
    word_t     dmem [0:255];
    logic      random_ready;
    integer    seed;
    string     test_name;
    int        err_count;
    wb_t       exp_wb [$];
    dmem_req_t exp_req [$];
    word_t     ref_regs [0:31];
    word_t     ref_mem [0:255];
    logic      prev_hold;
    dmem_req_t prev_req;
    word_t     fetch_idx;

    rv_core #(
        .RESET_PC   (reset_pc)
    ) dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_rdata (imem_rdata),
        .dmem_ready (dmem_ready),
        .dmem_rdata (dmem_rdata),
        .imem_addr  (imem_addr),
        .dmem_valid (dmem_valid),
        .dmem_req   (dmem_req),
        .wb         (wb)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////
    // memory models
    ////////////////////

    // past the program the core fetches zeros, which decode as bubbles
    always_comb begin
        fetch_idx = (imem_addr - reset_pc) >> 2;
        if (imem_addr >= reset_pc && fetch_idx < word_t'(prog_len)) begin
            imem_rdata = prog[fetch_idx[5:0]];
        end else begin
            imem_rdata = '0;
        end
    end

    assign dmem_rdata = dmem[dmem_req.addr[9:2]];

    function automatic word_t dmem_fill(int idx);
        word_t a;
        a = word_t'(idx) << 2;
        return a ^ 32'h5ca1_ab1e ^ (a << 13);
    endfunction

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 256; i++) begin
                dmem[i] <= dmem_fill(i);
            end
        end else if (dmem_valid && dmem_ready && dmem_req.write) begin
            dmem[dmem_req.addr[9:2]] <= dmem_req.wdata;
        end
        if (random_ready) begin
            dmem_ready <= ($random(seed) % 2) != 0;
        end else begin
            dmem_ready <= 1'b1;
        end
    end

    ////////////////////
    // checks
    ////////////////////

    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "run stopped");
    endtask

    task automatic check_wb(string name, wb_t exp, wb_t act);
        if (act !== exp) begin
            err_count++;
            $display("ERR %s expected rd %0d value %h, actual valid %b rd %0d value %h",
                     name, exp.rd, exp.value, act.valid, act.rd, act.value);
            abort_run("retire mismatch");
        end
    endtask

    task automatic check_req(string name, dmem_req_t exp, dmem_req_t act);
        if (act !== exp) begin
            err_count++;
            $display("ERR %s expected %h %h %b, actual %h %h %b", name,
                     exp.addr, exp.wdata, exp.write, act.addr, act.wdata, act.write);
            abort_run("data request mismatch");
        end
    endtask

    task automatic check_word(string name, word_t exp, word_t act);
        if (act !== exp) begin
            err_count++;
            $display("ERR %s expected %h actual %h", name, exp, act);
            abort_run("word mismatch");
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            err_count++;
            $display("ERR %s expected %b actual %b", name, exp, act);
            abort_run("control bit mismatch");
        end
    endtask

    ////////////////////
    // instruction encoders
    ////////////////////

    function automatic word_t r_type(logic [6:0] f7, logic [2:0] f3, reg_addr_t rd,
                                     reg_addr_t rs1, reg_addr_t rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t i_type(logic [2:0] f3, logic [6:0] op, reg_addr_t rd,
                                     reg_addr_t rs1, int imm);
        word_t u;
        u = word_t'(imm);
        return {u[11:0], rs1, f3, rd, op};
    endfunction

    function automatic word_t s_type(reg_addr_t rs1, reg_addr_t rs2, int imm);
        word_t u;
        u = word_t'(imm);
        return {u[11:5], rs2, rs1, 3'b010, u[4:0], 7'b0100011};
    endfunction

    function automatic word_t b_type(logic [2:0] f3, reg_addr_t rs1, reg_addr_t rs2, int imm);
        word_t u;
        u = word_t'(imm);
        return {u[12], u[10:5], rs2, rs1, f3, u[4:1], u[11], 7'b1100011};
    endfunction

    function automatic word_t j_type(reg_addr_t rd, int imm);
        word_t u;
        u = word_t'(imm);
        return {u[20], u[10:1], u[11], u[19:12], rd, 7'b1101111};
    endfunction

    task automatic put(word_t w);
        prog[prog_len] = w;
        prog_len++;
    endtask

    ////////////////////
    // reference model
    ////////////////////

    // architectural run with one delay slot after every branch and jump
    task automatic build_expected();
        word_t pc;
        word_t npc;
        word_t nnpc;
        word_t ins;
        word_t a;
        word_t b;
        word_t val;
        word_t addr;
        logic  taken;
        logic  wr;
        int    steps;
        exp_wb.delete();
        exp_req.delete();
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            ref_mem[i] = dmem_fill(i);
        end
        pc = reset_pc;
        npc = reset_pc + 4;
        steps = 0;
        while (pc >= reset_pc && ((pc - reset_pc) >> 2) < word_t'(prog_len) && steps < 200) begin
            ins = prog[((pc - reset_pc) >> 2)];
            a = ref_regs[ins[19:15]];
            b = ref_regs[ins[24:20]];
            taken = 1'b0;
            wr = 1'b1;
            val = '0;
            nnpc = npc + 4;
            case (ins[6:0])
                7'b0110011: begin
                    case ({ins[30], ins[14:12]})
                        4'b0000: val = a + b;
                        4'b1000: val = a - b;
                        4'b0111: val = a & b;
                        4'b0110: val = a | b;
                        4'b0100: val = a ^ b;
                        default: val = {31'd0, $signed(a) < $signed(b)};
                    endcase
                end
                7'b0010011: val = a + {{20{ins[31]}}, ins[31:20]};
                7'b0000011: begin
                    addr = a + {{20{ins[31]}}, ins[31:20]};
                    exp_req.push_back('{addr: addr, wdata: '0, write: 1'b0});
                    val = ref_mem[addr[9:2]];
                end
                7'b0100011: begin
                    wr = 1'b0;
                    addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    exp_req.push_back('{addr: addr, wdata: b, write: 1'b1});
                    ref_mem[addr[9:2]] = b;
                end
                7'b1100011: begin
                    wr = 1'b0;
                    case (ins[14:12])
                        3'b000:  taken = (a == b);
                        3'b001:  taken = (a != b);
                        default: taken = $signed(a) < $signed(b);
                    endcase
                    if (taken) begin
                        nnpc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
                                     ins[11:8], 1'b0};
                    end
                end
                default: begin
                    val = pc + 4;
                    nnpc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20],
                                 ins[30:21], 1'b0};
                end
            endcase
            if (wr) begin
                exp_wb.push_back('{valid: 1'b1, rd: ins[11:7], value: val});
                if (ins[11:7] != 5'd0) begin
                    ref_regs[ins[11:7]] = val;
                end
            end
            pc = npc;
            npc = nnpc;
            steps++;
        end
    endtask

    ////////////////////
    // run control
    ////////////////////

    task automatic reset_dut();
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (9) @(posedge clk);
        @(negedge clk);
        check_word({test_name, " reset pc"}, reset_pc, imem_addr);
        check_bit({test_name, " reset dmem_valid"}, 1'b0, dmem_valid);
        check_bit({test_name, " reset wb.valid"}, 1'b0, wb.valid);
        @(posedge clk);
        rst_n <= 1'b1;
    endtask

    // outputs settle after the rising edge, so look at the falling one
    task automatic monitor_cycle();
        dmem_req_t act;
        @(negedge clk);
        if (wb.valid) begin
            if (exp_wb.size() == 0) begin
                abort_run({test_name, ": an instruction retired that should not have"});
            end else begin
                check_wb(test_name, exp_wb.pop_front(), wb);
            end
        end
        if (prev_hold) begin
            check_bit({test_name, " held valid"}, 1'b1, dmem_valid);
            check_req({test_name, " held request"}, prev_req, dmem_req);
        end
        if (dmem_valid && dmem_ready) begin
            if (exp_req.size() == 0) begin
                abort_run({test_name, ": a data request was made that should not have"});
            end else begin
                act = dmem_req;
                if (!act.write) begin
                    act.wdata = '0;
                end
                check_req(test_name, exp_req.pop_front(), act);
            end
        end
        prev_hold = dmem_valid && !dmem_ready;
        prev_req = dmem_req;
    endtask

    task automatic run_program(string name, logic rnd);
        test_name = name;
        random_ready = rnd;
        build_expected();
        reset_dut();
        prev_hold = 1'b0;
        while (exp_wb.size() > 0 || exp_req.size() > 0) begin
            monitor_cycle();
        end
        // nothing else may retire afterwards
        repeat (8) monitor_cycle();
    endtask

    `include "tb_tests.svh"

    initial begin
        seed = 32'ha43545d5;
        err_count = 0;
        prog_len = 0;
        random_ready = 1'b0;
        rst_n <= 1'b0;
        dmem_ready <= 1'b1;
        test_reset();
        test_alu(1'b0);
        test_mem(1'b0);
        test_branch(1'b0);
        test_alu(1'b1);
        test_mem(1'b1);
        test_branch(1'b1);
        if (err_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: the tests did not finish in %0d cycles", watchdog_cycles);
        $display("=== FAIL ===");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: project.f
+incdir+.
rv_pkg.sv
fetch_stage.sv
reg_file.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
rv_core.sv
tb_core.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the tb_core simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module tb_core -o tb_core_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_core_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulator returned status $sim_status"
    exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
    echo "no result line in sim.log"
    exit 1
fi
exit 0
